// ==== files.f ====
+incdir+include
rtl/fetch_pkg.sv
rtl/icache.sv
rtl/ifu.sv
rtl/fetch_top.sv
sim/fetch_mem_model.sv
sim/fetch_tb.sv

// ==== include/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first fetch after reset, boot code in flash
`define FETCH_RESET_PC 32'h3000_0000

// cached window, base inclusive and limit exclusive
`define SDRAM_BASE  32'ha000_0000
`define SDRAM_LIMIT 32'ha200_0000

// 32-byte lines
`define ICACHE_LINE_WORDS 8

// direct mapped, one line per set
`define ICACHE_SETS 16

// arburst codes
`define BURST_FIXED 2'b00
`define BURST_INCR  2'b01

`endif

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

	localparam int OFF_W = $clog2(`ICACHE_LINE_WORDS); // word within line
	localparam int IDX_W = $clog2(`ICACHE_SETS);       // set select
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2;     // rest above the index

	typedef logic [31:0]      addr_t;     // byte address
	typedef logic [31:0]      word_t;     // instruction or beat
	typedef logic [OFF_W-1:0] line_off_t;
	typedef logic [IDX_W-1:0] set_idx_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [1:0]       burst_t;    // arburst field

	function automatic logic in_sdram(input addr_t a);
		return (a >= `SDRAM_BASE) && (a < `SDRAM_LIMIT);
	endfunction

	function automatic line_off_t addr_off(input addr_t a);
		return a[OFF_W+1:2]; // byte offset bits dropped
	endfunction

	function automatic set_idx_t addr_idx(input addr_t a);
		return a[IDX_W+OFF_W+1:OFF_W+2];
	endfunction

	function automatic tag_t addr_tag(input addr_t a);
		return a[31:IDX_W+OFF_W+2];
	endfunction

	function automatic addr_t line_base(input addr_t a);
		return a & ~addr_t'(`ICACHE_LINE_WORDS * 4 - 1); // first word of the line
	endfunction

endpackage

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  logic   clock,
	input  logic   reset,

	output addr_t  araddr,
	output burst_t arburst,
	output logic [3:0] arlen,
	output logic   arvalid,
	input  logic   arready,
	input  word_t  rdata,
	input  logic [1:0] rresp,   // not checked, error beats used as data
	input  logic   rlast,
	input  logic   rvalid,

	input  logic   jump_wrong,
	input  addr_t  jump_addr,
	input  addr_t  dnpc,

	output addr_t  pc,
	output addr_t  pc_next,
	output addr_t  dnpc_next,
	output word_t  inst,
	output logic   inst_valid,
	input  logic   inst_ready
);

	addr_t lookup_addr;   // ifu to cache
	logic  lookup_strobe;
	logic  hit_valid;
	logic  hit;
	word_t hit_data;
	logic  fill_valid;    // refill words
	addr_t fill_addr;
	word_t fill_data;

	ifu u_ifu (
		.clock         (clock),
		.reset         (reset),
		.araddr        (araddr),
		.arburst       (arburst),
		.arlen         (arlen),
		.arvalid       (arvalid),
		.arready       (arready),
		.rdata         (rdata),
		.rlast         (rlast),
		.rvalid        (rvalid),
		.jump_wrong    (jump_wrong),
		.jump_addr     (jump_addr),
		.dnpc          (dnpc),
		.pc            (pc),
		.pc_next       (pc_next),
		.dnpc_next     (dnpc_next),
		.inst          (inst),
		.inst_valid    (inst_valid),
		.inst_ready    (inst_ready),
		.lookup_addr   (lookup_addr),
		.lookup_strobe (lookup_strobe),
		.hit_valid     (hit_valid),
		.hit           (hit),
		.hit_data      (hit_data),
		.fill_valid    (fill_valid),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data)
	);

	icache u_icache (
		.clock         (clock),
		.reset         (reset),
		.lookup_addr   (lookup_addr),
		.lookup_strobe (lookup_strobe),
		.hit_valid     (hit_valid),
		.hit           (hit),
		.hit_data      (hit_data),
		.fill_valid    (fill_valid),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data)
	);

endmodule

`default_nettype wire

// ==== rtl/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module icache import fetch_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  addr_t lookup_addr,   // pc of the fetch
	input  logic  lookup_strobe,
	output logic  hit_valid,     // answer one cycle after strobe
	output logic  hit,
	output word_t hit_data,
	input  logic  fill_valid,    // one refill word
	input  addr_t fill_addr,
	input  word_t fill_data
);

	logic [`ICACHE_SETS-1:0] valid_q;
	tag_t                    tag_q [`ICACHE_SETS];
	word_t                   data_q [`ICACHE_SETS][`ICACHE_LINE_WORDS];

	set_idx_t  look_idx_q; // registered lookup
	tag_t      look_tag_q;
	line_off_t look_off_q;

	set_idx_t  fill_idx;
	line_off_t fill_off;
	tag_t      fill_tag;
	logic      fill_first; // offset 0, start of a refill
	logic      fill_last;  // offset 7, line complete

	set_idx_t  refill_idx_q; // line being refilled
	tag_t      refill_tag_q;

	assign fill_idx   = addr_idx(fill_addr);
	assign fill_off   = addr_off(fill_addr);
	assign fill_tag   = addr_tag(fill_addr);
	assign fill_first = (fill_off == '0);
	assign fill_last  = (fill_off == '1);

	always_ff @(posedge clock) begin
		if (reset) begin
			hit_valid <= 1'b0;
		end else begin
			hit_valid <= lookup_strobe; // single pulse per strobe
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_strobe) begin
			look_idx_q <= addr_idx(lookup_addr);
			look_tag_q <= addr_tag(lookup_addr);
			look_off_q <= addr_off(lookup_addr);
		end
	end

	// compare against the stored line after the index register
	assign hit      = valid_q[look_idx_q] && (tag_q[look_idx_q] == look_tag_q);
	assign hit_data = data_q[look_idx_q][look_off_q];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else if (fill_valid) begin
			if (fill_last) begin
				valid_q[fill_idx] <= 1'b1; // whole line present now
			end else if (fill_first) begin
				valid_q[fill_idx] <= 1'b0; // old contents being overwritten
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_q[fill_idx][fill_off] <= fill_data;
			if (fill_first) begin
				refill_idx_q <= fill_idx;
				refill_tag_q <= fill_tag;
			end
			if (fill_last) begin
				tag_q[fill_idx] <= refill_tag_q; // tag of the burst that started the line
			end
		end
	end

	// later words of a refill stay in the line the first word opened
	a_fill_same_line: assert property (@(posedge clock) disable iff (reset)
		fill_valid && !fill_first |-> fill_idx == refill_idx_q && fill_tag == refill_tag_q);

endmodule

`default_nettype wire

// ==== rtl/ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module ifu import fetch_pkg::*; (
	input  logic   clock,
	input  logic   reset,

	output addr_t  araddr,
	output burst_t arburst,
	output logic [3:0] arlen,
	output logic   arvalid,
	input  logic   arready,
	input  word_t  rdata,
	input  logic   rlast,
	input  logic   rvalid,

	input  logic   jump_wrong,    // one-cycle redirect
	input  addr_t  jump_addr,
	input  addr_t  dnpc,          // next address for the current pc

	output addr_t  pc,
	output addr_t  pc_next,       // pc of inst
	output addr_t  dnpc_next,     // dnpc seen for inst
	output word_t  inst,
	output logic   inst_valid,
	input  logic   inst_ready,

	output addr_t  lookup_addr,
	output logic   lookup_strobe,
	input  logic   hit_valid,
	input  logic   hit,
	input  word_t  hit_data,
	output logic   fill_valid,
	output addr_t  fill_addr,
	output word_t  fill_data
);

	typedef enum logic [1:0] {
		S_WAIT, // waiting for room at decode
		S_REQ,  // address phase on the read channel
		S_DATA, // read beats coming in
		S_HIT   // cache answer due
	} state_t;

	state_t state_q;
	logic   slot_free;    // decode can take a new inst
	logic   pc_sdram;
	logic   bus_busy;     // request or burst outstanding
	logic   beat;
	logic   burst_end;
	logic   deliver_beat;
	logic   deliver_hit;
	logic   deliver;
	word_t  deliver_word;

	logic   want_q;       // word at pc offset not seen yet
	logic   burst_q;      // current read refills a line
	addr_t  beat_addr_q;  // address of the next beat
	logic   redir_q;      // redirect waits for the burst to drain
	addr_t  redir_addr_q;

	assign slot_free = ~inst_valid | inst_ready;
	assign pc_sdram  = in_sdram(pc);
	assign bus_busy  = (state_q == S_REQ) | (state_q == S_DATA);

	assign lookup_addr   = pc;
	assign lookup_strobe = (state_q == S_WAIT) & slot_free & pc_sdram & ~jump_wrong;

	// sdram misses fetch the whole line, flash a single word
	assign arvalid = (state_q == S_REQ);
	assign araddr  = pc_sdram ? line_base(pc) : pc;
	assign arburst = pc_sdram ? `BURST_INCR : `BURST_FIXED;
	assign arlen   = pc_sdram ? 4'(`ICACHE_LINE_WORDS - 1) : 4'd0;

	assign beat      = (state_q == S_DATA) & rvalid; // rready is tied high
	assign burst_end = beat & rlast;

	assign fill_valid = beat & burst_q;
	assign fill_addr  = beat_addr_q;
	assign fill_data  = rdata;

	// flash beat address equals pc, so the offset test holds there too
	assign deliver_beat = beat & want_q & ~jump_wrong & (addr_off(beat_addr_q) == addr_off(pc));
	assign deliver_hit  = (state_q == S_HIT) & hit_valid & hit & ~jump_wrong;
	assign deliver      = deliver_beat | deliver_hit;
	assign deliver_word = deliver_hit ? hit_data : rdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= S_REQ; // reset pc lies in flash
		end else begin
			case (state_q)
				S_WAIT: begin
					if (slot_free & ~jump_wrong) begin
						state_q <= pc_sdram ? S_HIT : S_REQ; // strobe goes out this cycle
					end
				end
				S_HIT: begin
					if (jump_wrong) begin
						state_q <= S_WAIT; // answer belongs to the old path
					end else if (hit_valid) begin
						state_q <= hit ? S_WAIT : S_REQ;
					end
				end
				S_REQ: begin
					if (arready) begin
						state_q <= S_DATA;
					end
				end
				default: begin
					if (burst_end) begin
						state_q <= S_WAIT;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			want_q <= 1'b0;
		end else if (jump_wrong | deliver_beat) begin
			want_q <= 1'b0;
		end else if ((state_q == S_REQ) & arready & ~redir_q) begin
			want_q <= 1'b1; // drained reads never deliver
		end
	end

	always_ff @(posedge clock) begin
		if ((state_q == S_REQ) & arready) begin
			burst_q     <= pc_sdram;
			beat_addr_q <= araddr;
		end else if (beat) begin
			beat_addr_q <= beat_addr_q + 32'd4; // incrementing burst
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			redir_q <= 1'b0;
		end else if (jump_wrong & bus_busy & ~burst_end) begin
			redir_q <= 1'b1;
		end else if (burst_end) begin
			redir_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (jump_wrong) begin
			redir_addr_q <= jump_addr; // latest target wins
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `FETCH_RESET_PC;
		end else if (jump_wrong & (~bus_busy | burst_end)) begin
			pc <= jump_addr; // nothing on the bus to drain
		end else if (burst_end & redir_q) begin
			pc <= redir_addr_q;
		end else if (deliver) begin
			pc <= dnpc;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			inst_valid <= 1'b0;
		end else if (jump_wrong) begin
			inst_valid <= 1'b0; // old path inst dropped
		end else if (deliver) begin
			inst_valid <= 1'b1;
		end else if (inst_ready) begin
			inst_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (deliver) begin
			inst      <= deliver_word;
			pc_next   <= pc;
			dnpc_next <= dnpc; // sampled as the fetch completes
		end
	end

	// address phase held until the slave takes it
	a_ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arburst));

	// cache never sees a refill word and a lookup together
	a_fill_no_lookup: assert property (@(posedge clock) disable iff (reset)
		!(fill_valid && lookup_strobe));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f files.f \
	--top-module fetch_tb \
	-o fetch_sim

# simulation status is taken from the log below
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== sim/fetch_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_mem_model import fetch_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  addr_t      araddr,
	input  burst_t     arburst,
	input  logic [3:0] arlen,
	input  logic       arvalid,
	output logic       arready,
	output word_t      rdata,
	output logic [1:0] rresp,
	output logic       rlast,
	output logic       rvalid,
	output int         ar_count   // accepted address handshakes
);

	word_t       mem [addr_t];    // words from the patterns file
	logic [31:0] rng;
	logic        busy;            // burst in progress
	addr_t       cur_addr;
	burst_t      cur_burst;
	int          beats_left;
	logic        ar_fire;
	logic        beat_fire;
	addr_t       req_addr;
	burst_t      req_burst;
	logic [3:0]  req_len;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// unlisted words still differ per address
	function automatic word_t word_at(input addr_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return a ^ 32'h1357_9bdf ^ {a[15:0], a[31:16]};
	endfunction

	initial begin
		int    fd;
		int    r;
		string line;
		addr_t a;
		word_t d;
		fd = $fopen("sim/fetch_patterns.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				r = $fgets(line, fd);
				if (r > 0 && line.len() > 0 && line[0] == "M") begin
					r = $sscanf(line, "M %h %h", a, d);
					mem[a] = d; // memory line only
				end
			end
			$fclose(fd);
		end
	end

	initial begin
		arready    = 1'b0;
		rvalid     = 1'b0;
		rdata      = '0;
		rresp      = 2'b00;
		rlast      = 1'b0;
		ar_count   = 0;
		rng        = 32'd41465;
		busy       = 1'b0;
		cur_addr   = '0;
		cur_burst  = `BURST_FIXED;
		beats_left = 0;
	end

	always begin
		@(negedge clock); // bus values settled here
		ar_fire   = arvalid & arready & ~reset;
		beat_fire = rvalid;
		req_addr  = araddr;
		req_burst = arburst;
		req_len   = arlen;
		if (ar_fire) begin
			ar_count = ar_count + 1;
		end
		@(posedge clock);
		#1;
		if (reset) begin
			busy    = 1'b0;
			arready = 1'b0;
			rvalid  = 1'b0;
			rlast   = 1'b0;
		end else begin
			if (beat_fire) begin
				beats_left = beats_left - 1;
				if (cur_burst == `BURST_INCR) begin
					cur_addr = cur_addr + 32'd4;
				end
				if (beats_left == 0) begin
					busy = 1'b0; // last beat taken
				end
			end
			if (ar_fire) begin
				busy       = 1'b1;
				cur_addr   = req_addr;
				cur_burst  = req_burst;
				beats_left = int'(req_len) + 1;
			end
			rng     = xorshift32(rng);
			arready = ~busy & rng[0];            // one read outstanding
			rvalid  = busy & (rng[2:1] != 2'b00); // gaps on data too
			rdata   = word_at(cur_addr);
			rlast   = busy && (beats_left == 1);
			rresp   = 2'b00;
		end
	end

endmodule

`default_nettype wire

// ==== sim/fetch_patterns.txt ====
# M <addr> <word> : memory word, hex
# S <pc> <dnpc> <stall> : expected pc (hex), dnpc returned (hex), cycles inst_ready held low
# R <cycles> <target> : jump_wrong pulse that many cycles into the next step (target hex)
M 30000000 00000093
M 30000004 00100113
M 30000008 00200193
M 30000010 00400293
M 30000020 00800313
M 30000024 00900393
M 30000028 00a00413
M a0000024 01100493
M a0000028 01200513
M a0000034 01300593
M a0000038 01400613
M a000003c 01500693
M a0000040 01600713
M a0000044 01700793
M a0000104 01800813
M a0000220 01900893
S 30000000 30000004 0
S 30000004 30000008 2
S 30000008 a0000034 0
S a0000034 a0000038 0
S a0000038 a0000024 3
S a0000024 a0000028 0
S a0000028 a0000220 0
S a0000220 a000003c 0
S a000003c 30000010 1
S 30000010 a0000100 0
R 4 30000020
S 30000020 30000024 0
S 30000024 30000028 0
R 12 a0000040
S a0000040 a0000044 0
S a0000044 a0000104 0
S a0000104 30000000 0
S 30000000 30000004 2

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb import fetch_pkg::*; ();

	logic       clock;
	logic       reset;
	addr_t      araddr;
	burst_t     arburst;
	logic [3:0] arlen;
	logic       arvalid;
	logic       arready;
	word_t      rdata;
	logic [1:0] rresp;
	logic       rlast;
	logic       rvalid;
	logic       jump_wrong;
	addr_t      jump_addr;
	addr_t      dnpc;
	addr_t      pc;
	addr_t      pc_next;
	addr_t      dnpc_next;
	word_t      inst;
	logic       inst_valid;
	logic       inst_ready;
	int         ar_count;

	word_t exp_mem [addr_t];
	addr_t step_pc [$];
	addr_t step_dnpc [$];
	int    step_stall [$];
	int    step_roff [$];   // -1 when no redirect
	addr_t step_rtgt [$];
	logic  parsed;

	// expected cache contents, known cleared where a drained refill may have landed
	logic [`ICACHE_SETS-1:0] model_valid;
	logic [`ICACHE_SETS-1:0] model_known;
	logic [31:0]             model_tag [`ICACHE_SETS];

	initial clock = 1'b0;
	always #2 clock = ~clock;

	fetch_top uut (
		.clock(clock), .reset(reset),
		.araddr(araddr), .arburst(arburst), .arlen(arlen), .arvalid(arvalid),
		.arready(arready), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid),
		.jump_wrong(jump_wrong), .jump_addr(jump_addr), .dnpc(dnpc),
		.pc(pc), .pc_next(pc_next), .dnpc_next(dnpc_next),
		.inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready)
	);

	fetch_mem_model u_mem (
		.clock(clock), .reset(reset),
		.araddr(araddr), .arburst(arburst), .arlen(arlen), .arvalid(arvalid),
		.arready(arready), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid),
		.ar_count(ar_count)
	);

	function automatic word_t expected_word(input addr_t a);
		if (exp_mem.exists(a)) begin
			return exp_mem[a];
		end
		return a ^ 32'h1357_9bdf ^ {a[15:0], a[31:16]}; // same fill as the memory
	endfunction

	function automatic logic is_cached(input addr_t a);
		return (a >= `SDRAM_BASE) && (a < `SDRAM_LIMIT);
	endfunction

	function automatic int set_of(input addr_t a);
		return int'((a / (`ICACHE_LINE_WORDS * 4)) % `ICACHE_SETS);
	endfunction

	function automatic logic [31:0] tag_of(input addr_t a);
		return a / (`ICACHE_LINE_WORDS * 4 * `ICACHE_SETS);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// request fields follow the region, line bursts for sdram and single beats for flash
	always @(negedge clock) begin
		if (!reset && arvalid && arready) begin
			if (is_cached(araddr)) begin
				check_value("sdram arburst", 32'(`BURST_INCR), 32'(arburst));
				check_value("sdram arlen", `ICACHE_LINE_WORDS - 1, 32'(arlen));
				check_value("sdram araddr offset", 32'd0, araddr % (`ICACHE_LINE_WORDS * 4));
			end else begin
				check_value("flash arburst", 32'(`BURST_FIXED), 32'(arburst));
				check_value("flash arlen", 32'd0, 32'(arlen));
			end
		end
	end

	task automatic read_patterns();
		int    fd;
		int    r;
		string line;
		addr_t a;
		addr_t b;
		int    n;
		int    roff;
		addr_t rtgt;
		roff = -1;
		rtgt = '0;
		fd = $fopen("sim/fetch_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the patterns file sim/fetch_patterns.txt");
			$display("Verification failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			r = $fgets(line, fd);
			if (r > 0 && line.len() > 0) begin
				if (line[0] == "M") begin
					r = $sscanf(line, "M %h %h", a, b);
					exp_mem[a] = b;
				end else if (line[0] == "R") begin
					r = $sscanf(line, "R %d %h", roff, rtgt); // applies to next step
				end else if (line[0] == "S") begin
					r = $sscanf(line, "S %h %h %d", a, b, n);
					step_pc.push_back(a);
					step_dnpc.push_back(b);
					step_stall.push_back(n);
					step_roff.push_back(roff);
					step_rtgt.push_back(rtgt);
					roff = -1;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic run_step(input int i);
		int    base_count;
		int    seen_count;
		int    s;
		logic  count_it;
		string tn;
		dnpc       = step_dnpc[i];
		base_count = ar_count;
		count_it   = 1'b1;
		if (step_roff[i] >= 0) begin
			count_it = 1'b0; // drained read adds an unknown handshake
			if (i > 0 && is_cached(step_dnpc[i-1])) begin
				model_known[set_of(step_dnpc[i-1])] = 1'b0;
			end
			repeat (step_roff[i]) begin
				@(posedge clock);
				#1;
			end
			jump_wrong = 1'b1;
			jump_addr  = step_rtgt[i];
			@(posedge clock);
			#1;
			jump_wrong = 1'b0;
		end
		while (!inst_valid) begin
			@(posedge clock);
			#1;
		end
		tn = $sformatf("step %0d", i);
		check_value({tn, " pc_next"}, step_pc[i], pc_next);
		check_value({tn, " dnpc_next"}, step_dnpc[i], dnpc_next);
		check_value({tn, " inst"}, expected_word(step_pc[i]), inst);
		check_value({tn, " pc"}, step_dnpc[i], pc);
		seen_count = ar_count;
		if (is_cached(step_pc[i])) begin
			s = set_of(step_pc[i]);
			if (count_it && model_known[s]) begin
				check_value({tn, " bursts"},
					(model_valid[s] && model_tag[s] == tag_of(step_pc[i])) ? 32'd0 : 32'd1,
					seen_count - base_count);
			end
			model_known[s] = 1'b1; // line now resident
			model_valid[s] = 1'b1;
			model_tag[s]   = tag_of(step_pc[i]);
		end else if (count_it) begin
			check_value({tn, " flash handshakes"}, 32'd1, seen_count - base_count);
		end
		repeat (step_stall[i]) begin
			@(posedge clock);
			#1;
			check_value({tn, " stall inst_valid"}, 32'd1, 32'(inst_valid));
			check_value({tn, " stall inst"}, expected_word(step_pc[i]), inst);
			check_value({tn, " stall pc"}, step_dnpc[i], pc);
			check_value({tn, " stall pc_next"}, step_pc[i], pc_next);
			check_value({tn, " stall dnpc_next"}, step_dnpc[i], dnpc_next);
			check_value({tn, " stall handshakes"}, seen_count, ar_count);
		end
		inst_ready = 1'b1;
		@(posedge clock);
		#1;
		inst_ready = 1'b0;
	endtask

	initial begin
		reset      = 1'b1;
		inst_ready = 1'b0;
		jump_wrong = 1'b0;
		jump_addr  = '0;
		dnpc       = '0;
		parsed     = 1'b0;
		read_patterns();
		parsed      = 1'b1;
		model_valid = '0; // cache cleared by reset
		model_known = '1;
		dnpc        = step_dnpc[0];
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int i = 0; i < step_pc.size(); i++) begin
			run_step(i);
		end
		$display("Verification passed");
		$finish;
	end

	initial begin
		wait (parsed);
		repeat (step_pc.size() * 200 + 20) @(posedge clock);
		$display("Fetch hung, an instruction did not arrive within the cycle budget");
		$display("Verification failed");
		$fatal(1);
	end

endmodule

`default_nettype wire
